/* obi_mem_cfg.svh */
`ifndef OBI_MEM_CFG_SVH
`define OBI_MEM_CFG_SVH

// ------------------------------------------------------------
// OBI bus widths
// ------------------------------------------------------------

// Byte address width, same on instruction and data port
`define OBI_ADDR_W 32

// Read and write data width
`define OBI_DATA_W 32

// ------------------------------------------------------------
// Bank and interrupt sizing
// ------------------------------------------------------------

// Words in the shared SRAM bank
`define BANK_DEPTH 1024

// Width of each interrupt source vector
`define IRQ_W 32

`endif

/* obi_mem_pkg.sv */
`default_nettype none

`include "obi_mem_cfg.svh"

package obi_mem_pkg;

  // Word index width into the bank
  localparam int unsigned BANK_AW = $clog2(`BANK_DEPTH);
  // Byte lanes per data word
  localparam int unsigned OBI_BE_W = `OBI_DATA_W / 8;

  // ------------------------------------------------------------
  // Request payloads as seen on the OBI side
  // ------------------------------------------------------------

  // Instruction fetch, read only so address alone
  typedef struct packed {
    logic [`OBI_ADDR_W-1:0] addr;
  } instr_req_t;

  // Data access with write fields
  typedef struct packed {
    logic [`OBI_ADDR_W-1:0] addr;
    logic                   we;
    logic [OBI_BE_W-1:0]    be;
    logic [`OBI_DATA_W-1:0] wdata;
  } data_req_t;

  // Common request into the arbiter, word addressed
  typedef struct packed {
    logic [BANK_AW-1:0]     idx;
    logic                   we;
    logic [OBI_BE_W-1:0]    be;
    logic [`OBI_DATA_W-1:0] wdata;
  } bank_req_t;

  // Interrupt cause ids, matching the core's irq line positions
  // NONE is what the id shows with nothing pending
  typedef enum logic [4:0] {
    IRQ_ID_NONE     = 5'd0,
    IRQ_ID_SOFTWARE = 5'd3,
    IRQ_ID_TIMER    = 5'd7,
    IRQ_ID_EXTERNAL = 5'd11,
    // Fast lines count up from 16
    IRQ_ID_FAST0    = 5'd16,
    IRQ_ID_FAST1, IRQ_ID_FAST2, IRQ_ID_FAST3, IRQ_ID_FAST4,
    IRQ_ID_FAST5, IRQ_ID_FAST6, IRQ_ID_FAST7, IRQ_ID_FAST8,
    IRQ_ID_FAST9, IRQ_ID_FAST10, IRQ_ID_FAST11, IRQ_ID_FAST12,
    IRQ_ID_FAST13, IRQ_ID_FAST14,
    // Non-maskable, top of the priority order
    IRQ_ID_NMI      = 5'd31
  } irq_id_e;

endpackage

`default_nettype wire

/* obi_req_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "obi_mem_cfg.svh"

module obi_req_port
  import obi_mem_pkg::*;
#(
  // Instruction or data payload
  parameter type payload_t = instr_req_t
) (
  input  logic      clk_i,
  input  logic      arst_n_i,
  // OBI request side
  input  logic      req_i,
  output logic      gnt_o,
  input  payload_t  payload_i,
  // Towards the bank arbiter
  output logic      bank_valid_o,
  input  logic      bank_ready_i,
  output bank_req_t bank_req_o
);

  // Payloads wider than a bare address carry write fields
  localparam bit HasWrite = ($bits(payload_t) > `OBI_ADDR_W);

  logic     full_q;
  payload_t buf_q;
  logic     take;
  logic     accept;

  // ------------------------------------------------------------
  // One-entry buffer handshake
  // ------------------------------------------------------------

  // Arbiter pulls the entry this cycle
  assign take = full_q & bank_ready_i;

  // Grant while empty, or while the entry leaves this cycle
  assign gnt_o = ~full_q | take;

  // OBI acceptance
  assign accept = req_i & gnt_o;

  assign bank_valid_o = full_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      full_q <= 1'b0;
    end else if (accept) begin
      // Refill wins when a new request lands on a drain
      full_q <= 1'b1;
    end else if (take) begin
      full_q <= 1'b0;
    end
  end

  // Payload capture
  always_ff @(posedge clk_i) begin
    if (accept) begin
      buf_q <= payload_i;
    end
  end

  // ------------------------------------------------------------
  // Widening to a bank request
  // ------------------------------------------------------------

  generate
    if (HasWrite) begin : g_rw
      data_req_t rw;

      assign rw = data_req_t'(buf_q);

      // Byte address down to word index
      assign bank_req_o = '{
        idx:   rw.addr[BANK_AW+1:2],
        we:    rw.we,
        be:    rw.be,
        wdata: rw.wdata
      };
    end else begin : g_ro
      instr_req_t ro;

      assign ro = instr_req_t'(buf_q);

      // Read-only bus, tie off write enable, full byte mask
      assign bank_req_o = '{
        idx:   ro.addr[BANK_AW+1:2],
        we:    1'b0,
        be:    '1,
        wdata: '0
      };
    end
  endgenerate

endmodule

`default_nettype wire

/* obi_bank_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "obi_mem_cfg.svh"

module obi_bank_arbiter
  import obi_mem_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  // Instruction port request
  input  logic                   instr_valid_i,
  output logic                   instr_ready_o,
  input  bank_req_t              instr_bank_i,
  // Data port request
  input  logic                   data_valid_i,
  output logic                   data_ready_o,
  input  bank_req_t              data_bank_i,
  // Responses, one cycle after the transfer
  output logic                   instr_rvalid_o,
  output logic [`OBI_DATA_W-1:0] instr_rdata_o,
  output logic                   data_rvalid_o,
  output logic [`OBI_DATA_W-1:0] data_rdata_o
);

  // Round-robin pointer, high when data goes first
  logic                   prefer_data_q;
  logic                   grant_instr;
  logic                   grant_data;
  logic                   xfer;
  bank_req_t              sel;
  // SRAM bank
  logic [`OBI_DATA_W-1:0] mem_q [`BANK_DEPTH];
  logic [`OBI_DATA_W-1:0] rdata_q;
  logic                   rvalid_q;
  // Response owner, high for the data port
  logic                   owner_data_q;

  // ------------------------------------------------------------
  // Round-robin arbitration
  // ------------------------------------------------------------

  // Data wins when alone or when it is its turn
  assign grant_data  = data_valid_i & (~instr_valid_i | prefer_data_q);
  assign grant_instr = instr_valid_i & ~grant_data;
  assign xfer        = grant_instr | grant_data;

  assign instr_ready_o = grant_instr;
  assign data_ready_o  = grant_data;

  // Winning request into the bank
  assign sel = grant_data ? data_bank_i : instr_bank_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      prefer_data_q <= 1'b0;
    end else if (xfer) begin
      // Other port goes first next time
      prefer_data_q <= grant_instr;
    end
  end

  // ------------------------------------------------------------
  // Bank access on the transfer edge
  // ------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (xfer) begin
      if (sel.we) begin
        // Only enabled byte lanes change
        for (int b = 0; b < OBI_BE_W; b++) begin
          if (sel.be[b]) begin
            mem_q[sel.idx][b*8 +: 8] <= sel.wdata[b*8 +: 8];
          end
        end
      end
      // Old word on a write, don't-care for the requester
      rdata_q <= mem_q[sel.idx];
    end
  end

  // ------------------------------------------------------------
  // Response routing
  // ------------------------------------------------------------

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q     <= 1'b0;
      owner_data_q <= 1'b0;
    end else begin
      rvalid_q     <= xfer;
      owner_data_q <= grant_data;
    end
  end

  // Owner flag steers the single response slot
  assign instr_rvalid_o = rvalid_q & ~owner_data_q;
  assign data_rvalid_o  = rvalid_q & owner_data_q;

  // Shared read register, qualified by rvalid
  assign instr_rdata_o = rdata_q;
  assign data_rdata_o  = rdata_q;

endmodule

`default_nettype wire

/* irq_aggregator.sv */
`timescale 1ns/1ps
`default_nettype none

`include "obi_mem_cfg.svh"

module irq_aggregator
  import obi_mem_pkg::*;
(
  input  logic              clk_i,
  input  logic              arst_n_i,
  // Environment and virtual-peripheral sources
  input  logic [`IRQ_W-1:0] irq_ext_i,
  input  logic [`IRQ_W-1:0] irq_vp_i,
  // Acknowledge from the core
  input  logic              irq_ack_i,
  input  irq_id_e           irq_ack_id_i,
  // Core interrupt lines
  output logic              irq_software_o,
  output logic              irq_timer_o,
  output logic              irq_external_o,
  output logic [14:0]       irq_fast_o,
  output logic              irq_nm_o,
  // Registered summary
  output logic              irq_pending_o,
  output irq_id_e           irq_id_o
);

  // Bits that map to a core line: 3, 7, 11 and 16 up to 31
  localparam logic [`IRQ_W-1:0] IrqMask = `IRQ_W'(32'hFFFF_0888);

  logic [`IRQ_W-1:0] src;
  logic [`IRQ_W-1:0] src_q;
  logic [`IRQ_W-1:0] rise;
  logic [`IRQ_W-1:0] ack_clr;
  logic [`IRQ_W-1:0] pending_d;
  logic [`IRQ_W-1:0] pending_q;
  irq_id_e           id_d;
  irq_id_e           id_q;
  logic              any_q;

  // ------------------------------------------------------------
  // Edge detect and pending set
  // ------------------------------------------------------------

  assign src  = irq_ext_i | irq_vp_i;
  assign rise = src & ~src_q;

  // One-hot clear of the acknowledged cause
  assign ack_clr = irq_ack_i ? (`IRQ_W'(1) << irq_ack_id_i) : '0;

  // A fresh edge beats a clear of the same bit
  assign pending_d = (pending_q & ~ack_clr) | (rise & IrqMask);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      src_q     <= '0;
      pending_q <= '0;
    end else begin
      src_q     <= src;
      pending_q <= pending_d;
    end
  end

  // Core lines straight from pending
  assign irq_software_o = pending_q[3];
  assign irq_timer_o    = pending_q[7];
  assign irq_external_o = pending_q[11];
  assign irq_fast_o     = pending_q[30:16];
  assign irq_nm_o       = pending_q[31];

  // ------------------------------------------------------------
  // Priority encoder
  // ------------------------------------------------------------

  // Later checks override, so lowest priority goes first
  always_comb begin
    id_d = IRQ_ID_NONE;
    if (pending_q[7]) id_d = IRQ_ID_TIMER;
    if (pending_q[3]) id_d = IRQ_ID_SOFTWARE;
    if (pending_q[11]) id_d = IRQ_ID_EXTERNAL;
    // Fast 30 ends up highest of the fast group
    for (int i = 16; i <= 30; i++) begin
      if (pending_q[i]) id_d = irq_id_e'(5'(i));
    end
    if (pending_q[31]) id_d = IRQ_ID_NMI;
  end

  // Summary one cycle behind pending
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      any_q <= 1'b0;
      id_q  <= IRQ_ID_NONE;
    end else begin
      any_q <= |pending_q;
      id_q  <= id_d;
    end
  end

  assign irq_pending_o = any_q;
  assign irq_id_o      = id_q;

endmodule

`default_nettype wire

/* core_mem_sys_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "obi_mem_cfg.svh"

module core_mem_sys_top
  import obi_mem_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  // Instruction bus, OBI read only
  input  logic                   instr_req_i,
  output logic                   instr_gnt_o,
  input  logic [`OBI_ADDR_W-1:0] instr_addr_i,
  output logic                   instr_rvalid_o,
  output logic [`OBI_DATA_W-1:0] instr_rdata_o,
  // Data bus, OBI read and write
  input  logic                   data_req_i,
  output logic                   data_gnt_o,
  input  logic [`OBI_ADDR_W-1:0] data_addr_i,
  input  logic                   data_we_i,
  input  logic [OBI_BE_W-1:0]    data_be_i,
  input  logic [`OBI_DATA_W-1:0] data_wdata_i,
  output logic                   data_rvalid_o,
  output logic [`OBI_DATA_W-1:0] data_rdata_o,
  // Interrupt sources and acknowledge
  input  logic [`IRQ_W-1:0]      irq_ext_i,
  input  logic [`IRQ_W-1:0]      irq_vp_i,
  input  logic                   irq_ack_i,
  input  irq_id_e                irq_ack_id_i,
  // Core interrupt lines
  output logic                   irq_software_o,
  output logic                   irq_timer_o,
  output logic                   irq_external_o,
  output logic [14:0]            irq_fast_o,
  output logic                   irq_nm_o,
  output logic                   irq_pending_o,
  output irq_id_e                irq_id_o
);

  instr_req_t instr_payload;
  data_req_t  data_payload;
  logic       instr_bank_valid;
  logic       instr_bank_ready;
  bank_req_t  instr_bank_req;
  logic       data_bank_valid;
  logic       data_bank_ready;
  bank_req_t  data_bank_req;

  // Bus fields into payload structs
  assign instr_payload = '{addr: instr_addr_i};
  assign data_payload  = '{
    addr:  data_addr_i,
    we:    data_we_i,
    be:    data_be_i,
    wdata: data_wdata_i
  };

  // ------------------------------------------------------------
  // Request ports
  // ------------------------------------------------------------

  obi_req_port #(
    .payload_t (instr_req_t)
  ) u_instr_port (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_i        (instr_req_i),
    .gnt_o        (instr_gnt_o),
    .payload_i    (instr_payload),
    .bank_valid_o (instr_bank_valid),
    .bank_ready_i (instr_bank_ready),
    .bank_req_o   (instr_bank_req)
  );

  obi_req_port #(
    .payload_t (data_req_t)
  ) u_data_port (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_i        (data_req_i),
    .gnt_o        (data_gnt_o),
    .payload_i    (data_payload),
    .bank_valid_o (data_bank_valid),
    .bank_ready_i (data_bank_ready),
    .bank_req_o   (data_bank_req)
  );

  // ------------------------------------------------------------
  // Shared bank
  // ------------------------------------------------------------

  obi_bank_arbiter u_bank_arbiter (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .instr_valid_i  (instr_bank_valid),
    .instr_ready_o  (instr_bank_ready),
    .instr_bank_i   (instr_bank_req),
    .data_valid_i   (data_bank_valid),
    .data_ready_o   (data_bank_ready),
    .data_bank_i    (data_bank_req),
    .instr_rvalid_o (instr_rvalid_o),
    .instr_rdata_o  (instr_rdata_o),
    .data_rvalid_o  (data_rvalid_o),
    .data_rdata_o   (data_rdata_o)
  );

  // Interrupts towards the core
  irq_aggregator u_irq_aggregator (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .irq_ext_i      (irq_ext_i),
    .irq_vp_i       (irq_vp_i),
    .irq_ack_i      (irq_ack_i),
    .irq_ack_id_i   (irq_ack_id_i),
    .irq_software_o (irq_software_o),
    .irq_timer_o    (irq_timer_o),
    .irq_external_o (irq_external_o),
    .irq_fast_o     (irq_fast_o),
    .irq_nm_o       (irq_nm_o),
    .irq_pending_o  (irq_pending_o),
    .irq_id_o       (irq_id_o)
  );

endmodule

`default_nettype wire

/* obi_mem_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module obi_mem_checker (
  input logic clk_i,
  input logic arst_n_i,
  input logic instr_req_i,
  input logic instr_gnt_o,
  input logic instr_rvalid_o,
  input logic data_req_i,
  input logic data_gnt_o,
  input logic data_rvalid_o,
  input logic data_full_i
);

  // Outstanding requests per port
  logic [7:0] instr_out_q;
  logic [7:0] data_out_q;
  // Count of failed assertions
  int         fail_count = 0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      instr_out_q <= '0;
      data_out_q  <= '0;
    end else begin
      instr_out_q <= instr_out_q + 8'(instr_req_i & instr_gnt_o) - 8'(instr_rvalid_o);
      data_out_q  <= data_out_q + 8'(data_req_i & data_gnt_o) - 8'(data_rvalid_o);
    end
  end

  a_instr_rvalid_owned: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    instr_rvalid_o |-> instr_out_q != 0)
    else begin
      $error("instr rvalid with nothing outstanding");
      fail_count++;
    end

  a_data_rvalid_owned: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    data_rvalid_o |-> data_out_q != 0)
    else begin
      $error("data rvalid with nothing outstanding");
      fail_count++;
    end

  // Empty buffers out of reset
  a_gnt_after_reset: assert property (@(posedge clk_i)
    $rose(arst_n_i) |-> instr_gnt_o && data_gnt_o)
    else begin
      $error("gnt low after reset");
      fail_count++;
    end

  // Stalled entry stays in the data buffer
  // Round robin lets it through on the next cycle
  a_stall_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (data_req_i && !data_gnt_o) |=> data_full_i && data_gnt_o)
    else begin
      $error("buffer drained or still stalled after a stall");
      fail_count++;
    end

endmodule

bind core_mem_sys_top obi_mem_checker u_obi_mem_checker (
  .clk_i          (clk_i),
  .arst_n_i       (arst_n_i),
  .instr_req_i    (instr_req_i),
  .instr_gnt_o    (instr_gnt_o),
  .instr_rvalid_o (instr_rvalid_o),
  .data_req_i     (data_req_i),
  .data_gnt_o     (data_gnt_o),
  .data_rvalid_o  (data_rvalid_o),
  .data_full_i    (u_data_port.full_q)
);

`default_nettype wire

/* tb_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "obi_mem_cfg.svh"

module tb_monitor
  import obi_mem_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   instr_req_i,
  input  logic                   instr_gnt_o,
  input  logic [`OBI_ADDR_W-1:0] instr_addr_i,
  input  logic                   instr_rvalid_o,
  input  logic [`OBI_DATA_W-1:0] instr_rdata_o,
  input  logic                   data_req_i,
  input  logic                   data_gnt_o,
  input  logic [`OBI_ADDR_W-1:0] data_addr_i,
  input  logic                   data_we_i,
  input  logic [3:0]             data_be_i,
  input  logic [`OBI_DATA_W-1:0] data_wdata_i,
  input  logic                   data_rvalid_o,
  input  logic [`OBI_DATA_W-1:0] data_rdata_o,
  input  logic [`IRQ_W-1:0]      irq_ext_i,
  input  logic [`IRQ_W-1:0]      irq_vp_i,
  input  logic                   irq_ack_i,
  input  irq_id_e                irq_ack_id_i,
  input  logic                   irq_software_o,
  input  logic                   irq_timer_o,
  input  logic                   irq_external_o,
  input  logic [14:0]            irq_fast_o,
  input  logic                   irq_nm_o,
  input  logic                   irq_pending_o,
  input  irq_id_e                irq_id_o,
  output logic                   idle_o,
  output int                     errors_o
);

  // Causes that have a core line
  localparam logic [31:0] CAUSES = 32'hFFFF_0888;

  logic [31:0] mem_m [`BANK_DEPTH];
  // Expected read word per port, bit 32 marks a write
  logic [32:0] instr_q [$];
  logic [32:0] data_q [$];
  int          errors;
  int          instr_acc, instr_ret, data_acc, data_ret;
  logic [31:0] src_m, pend_m, src_now, clr_now;
  logic [4:0]  id_m;
  logic        any_m;

  assign errors_o = errors;
  assign idle_o   = (instr_q.size() == 0) && (data_q.size() == 0) && !instr_req_i
                    && !data_req_i;

  initial begin
    errors    = 0;
    instr_acc = 0;
    instr_ret = 0;
    data_acc  = 0;
    data_ret  = 0;
  end

  // Highest pending cause, nmi first and timer last
  function automatic logic [4:0] top_cause(input logic [31:0] p);
    if (p[31]) return 5'd31;
    for (int i = 30; i >= 16; i--) begin
      if (p[i]) return 5'(i);
    end
    if (p[11]) return 5'd11;
    if (p[3]) return 5'd3;
    if (p[7]) return 5'd7;
    return 5'd0;
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  // ------------------------------------------------------------
  // Memory model and per-port response order
  // ------------------------------------------------------------

  always @(negedge clk_i) begin
    if (arst_n_i) begin
      // Responses first, they belong to earlier acceptances
      if (instr_rvalid_o) begin
        instr_ret++;
        if (instr_q.size() == 0) begin
          $display("Instruction rvalid without an outstanding request");
          errors++;
        end else check("instr_read", instr_q.pop_front(), instr_rdata_o);
      end
      if (data_rvalid_o) begin
        data_ret++;
        if (data_q.size() == 0) begin
          $display("Data rvalid without an outstanding request");
          errors++;
        end else begin
          logic [32:0] e;
          e = data_q.pop_front();
          if (!e[32]) check("data_read", e[31:0], data_rdata_o);
        end
      end
      if (instr_req_i && instr_gnt_o) begin
        instr_acc++;
        instr_q.push_back({1'b0, mem_m[instr_addr_i[11:2]]});
      end
      if (data_req_i && data_gnt_o) begin
        data_acc++;
        if (data_we_i) begin
          for (int b = 0; b < 4; b++) begin
            if (data_be_i[b]) mem_m[data_addr_i[11:2]][b*8 +: 8] = data_wdata_i[b*8 +: 8];
          end
          data_q.push_back({1'b1, 32'd0});
        end else data_q.push_back({1'b0, mem_m[data_addr_i[11:2]]});
      end
    end
  end

  // ------------------------------------------------------------
  // Interrupt model
  // ------------------------------------------------------------

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      src_m  <= '0;
      pend_m <= '0;
      id_m   <= '0;
      any_m  <= 1'b0;
    end else begin
      src_now = irq_ext_i | irq_vp_i;
      clr_now = irq_ack_i ? (32'd1 << irq_ack_id_i) : 32'd0;
      any_m  <= |(pend_m & CAUSES);
      id_m   <= top_cause(pend_m);
      // New edge beats a clear
      pend_m <= (pend_m & ~clr_now) | (src_now & ~src_m & CAUSES);
      src_m  <= src_now;
    end
  end

  always @(negedge clk_i) begin
    if (arst_n_i) begin
      check("irq_lines", {13'd0, pend_m[31:16], pend_m[11], pend_m[3], pend_m[7]},
            {13'd0, irq_nm_o, irq_fast_o, irq_external_o, irq_software_o, irq_timer_o});
      check("irq_id", {27'd0, id_m}, {27'd0, irq_id_o});
      check("irq_pending", {31'd0, any_m}, {31'd0, irq_pending_o});
    end
  end

  task automatic print_summary();
    if (instr_acc != instr_ret || data_acc != data_ret) begin
      $display("Accepted and returned request counts do not match");
      errors++;
    end
    $display("instr accepted %0d returned %0d, data accepted %0d returned %0d, errors %0d",
             instr_acc, instr_ret, data_acc, data_ret, errors);
  endtask

endmodule

`default_nettype wire

/* tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "obi_mem_cfg.svh"

module tb_top
  import obi_mem_pkg::*;
;

  // Transaction counts per phase
  localparam int N_INIT = 32;
  localparam int N_RAND = 200;
  localparam int N_IRQ  = 60;
  localparam int N_TXN  = 2 * N_INIT + 2 * N_RAND + N_IRQ;
  // 20 cycles per transaction plus margin, in ns
  localparam int TIMEOUT_NS = (N_TXN * 20 + 200) * 40;

  logic                   clk_i;
  logic                   arst_n_i;
  logic                   instr_req_i;
  logic                   instr_gnt_o;
  logic [`OBI_ADDR_W-1:0] instr_addr_i;
  logic                   instr_rvalid_o;
  logic [`OBI_DATA_W-1:0] instr_rdata_o;
  logic                   data_req_i;
  logic                   data_gnt_o;
  logic [`OBI_ADDR_W-1:0] data_addr_i;
  logic                   data_we_i;
  logic [3:0]             data_be_i;
  logic [`OBI_DATA_W-1:0] data_wdata_i;
  logic                   data_rvalid_o;
  logic [`OBI_DATA_W-1:0] data_rdata_o;
  logic [`IRQ_W-1:0]      irq_ext_i;
  logic [`IRQ_W-1:0]      irq_vp_i;
  logic                   irq_ack_i;
  irq_id_e                irq_ack_id_i;
  logic                   irq_software_o;
  logic                   irq_timer_o;
  logic                   irq_external_o;
  logic [14:0]            irq_fast_o;
  logic                   irq_nm_o;
  logic                   irq_pending_o;
  irq_id_e                irq_id_o;
  logic                   mon_idle;
  int                     mon_errors;
  integer                 seed;

  // 40 ns clock
  always #20 clk_i = ~clk_i;

  core_mem_sys_top u_core_mem_sys_top (.*);

  tb_monitor u_monitor (
    .clk_i, .arst_n_i, .instr_req_i, .instr_gnt_o, .instr_addr_i, .instr_rvalid_o,
    .instr_rdata_o, .data_req_i, .data_gnt_o, .data_addr_i, .data_we_i, .data_be_i,
    .data_wdata_i, .data_rvalid_o, .data_rdata_o, .irq_ext_i, .irq_vp_i, .irq_ack_i,
    .irq_ack_id_i, .irq_software_o, .irq_timer_o, .irq_external_o, .irq_fast_o,
    .irq_nm_o, .irq_pending_o, .irq_id_o,
    .idle_o   (mon_idle),
    .errors_o (mon_errors)
  );

  // ------------------------------------------------------------
  // Bus drivers, request held until gnt
  // ------------------------------------------------------------

  // Starts on a rising edge and returns on the accepting edge
  // Request stays high so the next access can follow back to back
  task automatic data_access(input int idx, input logic we, input logic [3:0] be,
                             input logic [31:0] wdata);
    data_req_i   <= 1'b1;
    data_addr_i  <= {20'd0, idx[9:0], 2'b00};
    data_we_i    <= we;
    data_be_i    <= be;
    data_wdata_i <= wdata;
    @(negedge clk_i);
    while (!data_gnt_o) @(negedge clk_i);
    // Accepted on this edge
    @(posedge clk_i);
  endtask

  task automatic instr_fetch(input int idx);
    instr_req_i  <= 1'b1;
    instr_addr_i <= {20'd0, idx[9:0], 2'b00};
    @(negedge clk_i);
    while (!instr_gnt_o) @(negedge clk_i);
    @(posedge clk_i);
  endtask

  // Ends on a rising edge with nothing in flight
  task automatic wait_drain();
    @(negedge clk_i);
    while (!mon_idle) @(negedge clk_i);
    @(posedge clk_i);
  endtask

  // Words 0..15 get data writes, 16..31 stay as initialized
  task automatic data_traffic();
    logic [31:0] r;
    logic [31:0] w;
    for (int n = 0; n < N_RAND; n++) begin
      r = $random(seed);
      w = $random(seed);
      if (r[0]) data_access(int'(r[4:1]), 1'b1, r[8:5], w);
      else data_access(int'(r[13:9]), 1'b0, 4'hF, 32'd0);
      if (r[20:18] == 3'd0) begin
        data_req_i <= 1'b0;
        @(posedge clk_i);
      end
    end
    data_req_i <= 1'b0;
  endtask

  task automatic instr_traffic();
    logic [31:0] r;
    for (int n = 0; n < N_RAND; n++) begin
      r = $random(seed);
      instr_fetch(16 + int'(r[3:0]));
      if (r[6:5] == 2'd0) begin
        instr_req_i <= 1'b0;
        @(posedge clk_i);
      end
    end
    instr_req_i <= 1'b0;
  endtask

  // Sparse edges on both vectors, ack of the reported id
  task automatic irq_traffic();
    logic [31:0] r;
    irq_id_e     cur;
    for (int n = 0; n < N_IRQ; n++) begin
      @(negedge clk_i);
      cur = irq_id_o;
      r   = $random(seed);
      @(posedge clk_i);
      irq_ext_i    <= $random(seed) & $random(seed) & $random(seed);
      irq_vp_i     <= $random(seed) & $random(seed) & $random(seed);
      irq_ack_i    <= r[0] && (cur != IRQ_ID_NONE);
      irq_ack_id_i <= cur;
    end
    @(posedge clk_i);
    irq_ack_i <= 1'b0;
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------

  initial begin
    seed         = 32'h761f_47df;
    clk_i        = 1'b0;
    arst_n_i     = 1'b0;
    instr_req_i  = 1'b0;
    instr_addr_i = '0;
    data_req_i   = 1'b0;
    data_addr_i  = '0;
    data_we_i    = 1'b0;
    data_be_i    = '0;
    data_wdata_i = '0;
    irq_ext_i    = '0;
    irq_vp_i     = '0;
    irq_ack_i    = 1'b0;
    irq_ack_id_i = IRQ_ID_NONE;
    repeat (5) @(posedge clk_i);
    arst_n_i <= 1'b1;
    // Full-word fill of the test window
    for (int i = 0; i < N_INIT; i++) begin
      data_access(i, 1'b1, 4'hF, {i[7:0], 8'hA5, 8'h5A, ~i[7:0]});
    end
    data_req_i <= 1'b0;
    wait_drain();
    // Both ports at once
    fork
      data_traffic();
      instr_traffic();
    join
    wait_drain();
    // Instruction view of the whole window after the writes
    for (int i = 0; i < N_INIT; i++) begin
      instr_fetch(i);
    end
    instr_req_i <= 1'b0;
    wait_drain();
    irq_traffic();
    repeat (3) @(posedge clk_i);
    u_monitor.print_summary();
    #1;
    if (mon_errors == 0 && u_core_mem_sys_top.u_obi_mem_checker.fail_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog timeout, the run did not complete in time");
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+.
obi_mem_pkg.sv
obi_req_port.sv
obi_bank_arbiter.sv
irq_aggregator.sv
core_mem_sys_top.sv
obi_mem_checker.sv
tb_monitor.sv
tb_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_top -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

echo "$out" | grep -q "^Everything OK$"
